//--- sim.f
source/fir_pkg.sv
source/fir_regs.sv
source/fir_sample_in.sv
source/fir_mac.sv
source/fir_result_out.sv
source/fir_engine.sv
dv/fir_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fir_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/fir_tb.sv
`timescale 1ns/1ps

module fir_tb;

    localparam int NUM_TAPS    = 11;
    localparam int RUN1_LEN    = 24;
    localparam int RUN2_LEN    = 16;
    localparam int MAX_RUN     = 32;
    localparam int READY_LEN   = 64;
    // coefficient used for the busy read and the ignored write
    localparam int BUSY_TAP    = 3;
    // gaps and back-pressure stretch each sample by at most this much
    localparam int STALL_FACTOR = 4;
    localparam int CYCLE_LIMIT =
        (RUN1_LEN + RUN2_LEN) * (NUM_TAPS + 3) * STALL_FACTOR + 600;

    logic           axis_clk;
    logic           axis_rst_n;
    logic           awvalid;
    fir_pkg::addr_t awaddr;
    logic           awready;
    logic           wvalid;
    fir_pkg::data_t wdata;
    logic           wready;
    logic           arvalid;
    fir_pkg::addr_t araddr;
    logic           arready;
    logic           rvalid;
    logic           rready;
    fir_pkg::data_t rdata;
    logic           ss_tvalid;
    fir_pkg::data_t ss_tdata;
    logic           ss_tlast;
    logic           ss_tready;
    logic           sm_tvalid;
    fir_pkg::data_t sm_tdata;
    logic           sm_tlast;
    logic           sm_tready;

    logic [31:0]    lfsr_state = 32'd29;
    int             cycle_count = 0;
    fir_pkg::data_t coef [NUM_TAPS];
    fir_pkg::data_t samples [MAX_RUN];
    fir_pkg::data_t expected [MAX_RUN];
    int             gaps [MAX_RUN];
    logic           ready_pat [READY_LEN];

    fir_engine #(
        .NUM_TAPS (NUM_TAPS)
    ) dut0 (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready)
    );

    initial begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    always @(posedge axis_clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            abort_run($sformatf("Timeout: the run did not finish within %0d cycles",
                                CYCLE_LIMIT));
        end
    end

    ////////////////////////////////////////////////////////////
    // random numbers and failure reporting
    ////////////////////////////////////////////////////////////

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic rand_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input fir_pkg::data_t got,
                              input fir_pkg::data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_ctrl(input string name, input fir_pkg::ap_ctrl_t got,
                              input fir_pkg::ap_ctrl_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    function automatic fir_pkg::ap_ctrl_t make_ctrl(input logic start, input logic done,
                                                    input logic idle);
        fir_pkg::ap_ctrl_t c;
        c       = '0;
        c.start = start;
        c.done  = done;
        c.idle  = idle;
        return c;
    endfunction

    function automatic fir_pkg::addr_t tap_addr(input int i);
        return fir_pkg::addr_t'(fir_pkg::ADDR_TAP_BASE + 4 * i);
    endfunction

    ////////////////////////////////////////////////////////////
    // register port
    ////////////////////////////////////////////////////////////

    task automatic reg_write(input fir_pkg::addr_t addr, input fir_pkg::data_t data);
        @(posedge axis_clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        do begin
            @(posedge axis_clk);
        end while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic reg_read(input fir_pkg::addr_t addr, output fir_pkg::data_t data);
        @(posedge axis_clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        do begin
            @(posedge axis_clk);
        end while (!arready);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        do begin
            @(posedge axis_clk);
        end while (!rvalid);
        data = rdata;
        rready <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // stream side and reference model
    ////////////////////////////////////////////////////////////

    // stimulus for one run, and the expected results from a fresh history
    task automatic prepare_run(input int n);
        logic [31:0]    r;
        fir_pkg::data_t hist_q [$];
        fir_pkg::data_t acc;
        for (int k = 0; k < n; k++) begin
            rand_bits(32, r);
            samples[k] = r;
            rand_bits(2, r);
            gaps[k] = int'(r[1:0]);
            hist_q.push_front(samples[k]);
            if (hist_q.size() > NUM_TAPS) begin
                void'(hist_q.pop_back());
            end
            // products and sum wrap at 32 bits
            acc = '0;
            for (int i = 0; i < hist_q.size(); i++) begin
                acc = acc + coef[i] * hist_q[i];
            end
            expected[k] = acc;
        end
        // ready three cycles out of four on average
        for (int c = 0; c < READY_LEN; c++) begin
            rand_bits(2, r);
            ready_pat[c] = (r[1:0] != 2'b00);
        end
    endtask

    task automatic send_samples(input int n);
        for (int k = 0; k < n; k++) begin
            if (gaps[k] > 0) begin
                ss_tvalid <= 1'b0;
                repeat (gaps[k]) @(posedge axis_clk);
            end
            ss_tvalid <= 1'b1;
            ss_tdata  <= samples[k];
            ss_tlast  <= (k == n - 1);
            do begin
                @(posedge axis_clk);
            end while (!(ss_tvalid && ss_tready));
        end
        ss_tvalid <= 1'b0;
        ss_tlast  <= 1'b0;
    endtask

    task automatic collect_results(input int n);
        int got;
        int cyc;
        got = 0;
        cyc = 0;
        while (got < n) begin
            @(posedge axis_clk);
            if (sm_tvalid && sm_tready) begin
                check_word($sformatf("sm_tdata[%0d]", got), sm_tdata, expected[got]);
                check_flag($sformatf("sm_tlast[%0d]", got), sm_tlast, got == n - 1);
                got++;
            end
            sm_tready <= ready_pat[cyc % READY_LEN];
            cyc++;
        end
        sm_tready <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        fir_pkg::data_t value;
        fir_pkg::data_t len_value;
        fir_pkg::data_t new_tap;
        logic [31:0]    r;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b0;
        repeat (2) @(posedge axis_clk);
        axis_rst_n <= 1'b1;

        // state after reset
        reg_read(fir_pkg::ADDR_AP_CTRL, value);
        check_ctrl("ap_ctrl", fir_pkg::ap_ctrl_t'(value), make_ctrl(1'b0, 1'b0, 1'b1));
        check_flag("ss_tready", ss_tready, 1'b0);
        check_flag("sm_tvalid", sm_tvalid, 1'b0);

        // coefficient and data_length readback while idle
        for (int i = 0; i < NUM_TAPS; i++) begin
            rand_bits(32, r);
            coef[i] = r;
            reg_write(tap_addr(i), coef[i]);
        end
        rand_bits(32, r);
        len_value = r;
        reg_write(fir_pkg::ADDR_DATA_LEN, len_value);
        for (int i = 0; i < NUM_TAPS; i++) begin
            reg_read(tap_addr(i), value);
            check_word($sformatf("tap[%0d]", i), value, coef[i]);
        end
        reg_read(fir_pkg::ADDR_DATA_LEN, value);
        check_word("data_length", value, len_value);

        // first run, with a busy coefficient access alongside
        prepare_run(RUN1_LEN);
        rand_bits(32, r);
        new_tap = r;
        reg_write(fir_pkg::ADDR_AP_CTRL, 32'h1);
        fork
            send_samples(RUN1_LEN);
            collect_results(RUN1_LEN);
            begin
                reg_read(tap_addr(BUSY_TAP), value);
                check_word("tap read while busy", value, fir_pkg::TAP_BUSY_VALUE);
                reg_write(tap_addr(BUSY_TAP), new_tap);
            end
        join

        // done is clear-on-read and that read brings idle back
        reg_read(fir_pkg::ADDR_AP_CTRL, value);
        check_ctrl("ap_ctrl", fir_pkg::ap_ctrl_t'(value), make_ctrl(1'b0, 1'b1, 1'b0));
        reg_read(fir_pkg::ADDR_AP_CTRL, value);
        check_ctrl("ap_ctrl", fir_pkg::ap_ctrl_t'(value), make_ctrl(1'b0, 1'b0, 1'b1));
        check_flag("sm_tvalid", sm_tvalid, 1'b0);
        reg_read(tap_addr(BUSY_TAP), value);
        check_word($sformatf("tap[%0d]", BUSY_TAP), value, coef[BUSY_TAP]);

        // second run starts from cleared history
        prepare_run(RUN2_LEN);
        reg_write(fir_pkg::ADDR_AP_CTRL, 32'h1);
        fork
            send_samples(RUN2_LEN);
            collect_results(RUN2_LEN);
        join
        reg_read(fir_pkg::ADDR_AP_CTRL, value);
        check_ctrl("ap_ctrl", fir_pkg::ap_ctrl_t'(value), make_ctrl(1'b0, 1'b1, 1'b0));
        reg_read(fir_pkg::ADDR_AP_CTRL, value);
        check_ctrl("ap_ctrl", fir_pkg::ap_ctrl_t'(value), make_ctrl(1'b0, 1'b0, 1'b1));

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- source/fir_engine.sv
`timescale 1ns/1ps

module fir_engine #(
    parameter int NUM_TAPS = 11
) (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    // register port
    input  logic           awvalid,
    input  fir_pkg::addr_t awaddr,
    output logic           awready,
    input  logic           wvalid,
    input  fir_pkg::data_t wdata,
    output logic           wready,
    input  logic           arvalid,
    input  fir_pkg::addr_t araddr,
    output logic           arready,
    output logic           rvalid,
    input  logic           rready,
    output fir_pkg::data_t rdata,
    // sample stream in
    input  logic           ss_tvalid,
    input  fir_pkg::data_t ss_tdata,
    input  logic           ss_tlast,
    output logic           ss_tready,
    // result stream out
    output logic           sm_tvalid,
    output fir_pkg::data_t sm_tdata,
    output logic           sm_tlast,
    input  logic           sm_tready
);

    fir_pkg::tap_bank_t taps;
    fir_pkg::tap_bank_t window;
    fir_pkg::sample_t   result;
    logic               start_pulse;
    logic               running;
    logic               last_done;
    logic               last_in;
    logic               pending;
    logic               take;
    logic               busy;
    logic               result_valid;
    logic               slot_free;

    fir_regs #(
        .NUM_TAPS (NUM_TAPS)
    ) regs0 (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awvalid     (awvalid),
        .awaddr      (awaddr),
        .awready     (awready),
        .wvalid      (wvalid),
        .wdata       (wdata),
        .wready      (wready),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arready     (arready),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .taps        (taps),
        .start_pulse (start_pulse),
        .running     (running),
        .last_done   (last_done)
    );

    fir_sample_in #(
        .NUM_TAPS (NUM_TAPS)
    ) sample_in0 (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .ss_tvalid   (ss_tvalid),
        .ss_tdata    (ss_tdata),
        .ss_tlast    (ss_tlast),
        .ss_tready   (ss_tready),
        .start_pulse (start_pulse),
        .running     (running),
        .take        (take),
        .busy        (busy),
        .window      (window),
        .last_in     (last_in),
        .pending     (pending)
    );

    fir_mac #(
        .NUM_TAPS (NUM_TAPS)
    ) mac0 (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .taps         (taps),
        .window       (window),
        .last_in      (last_in),
        .pending      (pending),
        .slot_free    (slot_free),
        .take         (take),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid)
    );

    fir_result_out result_out0 (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .result       (result),
        .result_valid (result_valid),
        .slot_free    (slot_free),
        .sm_tvalid    (sm_tvalid),
        .sm_tdata     (sm_tdata),
        .sm_tlast     (sm_tlast),
        .sm_tready    (sm_tready),
        .last_done    (last_done)
    );

endmodule

//--- source/fir_result_out.sv
`timescale 1ns/1ps

module fir_result_out (
    input  logic             axis_clk,
    input  logic             axis_rst_n,
    input  fir_pkg::sample_t result,
    input  logic             result_valid,
    output logic             slot_free,
    output logic             sm_tvalid,
    output fir_pkg::data_t   sm_tdata,
    output logic             sm_tlast,
    input  logic             sm_tready,
    output logic             last_done
);

    fir_pkg::sample_t out_q;
    logic             load;

    // room when empty or when the held beat leaves this cycle
    assign slot_free = ~sm_tvalid | sm_tready;
    assign load      = result_valid & slot_free;

    assign sm_tdata  = out_q.data;
    assign sm_tlast  = sm_tvalid & out_q.last;
    // final beat of a run accepted
    assign last_done = sm_tvalid & sm_tready & out_q.last;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            sm_tvalid <= 1'b0;
        end else if (load) begin
            sm_tvalid <= 1'b1;
        end else if (sm_tready) begin
            sm_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (load) begin
            out_q <= result;
        end
    end

endmodule

//--- source/fir_mac.sv
`timescale 1ns/1ps

module fir_mac #(
    parameter int NUM_TAPS = 11
) (
    input  logic               axis_clk,
    input  logic               axis_rst_n,
    input  fir_pkg::tap_bank_t taps,
    input  fir_pkg::tap_bank_t window,
    input  logic               last_in,
    input  logic               pending,
    input  logic               slot_free,
    output logic               take,
    output logic               busy,
    output fir_pkg::sample_t   result,
    output logic               result_valid
);

    localparam int IDX_W = fir_pkg::TAP_IDX_WIDTH;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_TAPS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_OFFER
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] idx;
    fir_pkg::data_t   acc;
    logic             last_q;

    assign take         = pending & (state == ST_IDLE);
    assign busy         = (state != ST_IDLE);
    assign result_valid = (state == ST_OFFER);
    assign result       = '{data: acc, last: last_q};

    ////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////

    // one tap per cycle, then hold the result until the output has room
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= ST_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pending) begin
                        state <= ST_CALC;
                        idx   <= '0;
                    end
                end
                ST_CALC: begin
                    idx <= idx + 1'b1;
                    if (idx == LAST_IDX) begin
                        state <= ST_OFFER;
                    end
                end
                ST_OFFER: begin
                    if (slot_free) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // accumulator
    ////////////////////////////////////////////////////////////

    // 32-bit context, so product and sum wrap
    always_ff @(posedge axis_clk) begin
        if (take) begin
            acc    <= '0;
            last_q <= last_in;
        end else if (state == ST_CALC) begin
            acc <= acc + taps[idx] * window[idx];
        end
    end

endmodule

//--- source/fir_sample_in.sv
`timescale 1ns/1ps

module fir_sample_in #(
    parameter int NUM_TAPS = 11
) (
    input  logic               axis_clk,
    input  logic               axis_rst_n,
    input  logic               ss_tvalid,
    input  fir_pkg::data_t     ss_tdata,
    input  logic               ss_tlast,
    output logic               ss_tready,
    input  logic               start_pulse,
    input  logic               running,
    input  logic               take,
    input  logic               busy,
    output fir_pkg::tap_bank_t window,
    output logic               last_in,
    output logic               pending
);

    fir_pkg::data_t hist [NUM_TAPS];
    logic           accept;

    // one sample at a time, only when the mac has room for it
    assign ss_tready = running & ~pending & ~busy;
    assign accept    = ss_tvalid & ss_tready;

    // history line, index 0 newest
    always_ff @(posedge axis_clk) begin
        if (start_pulse) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                hist[i] <= '0;
            end
            last_in <= 1'b0;
        end else if (accept) begin
            hist[0] <= ss_tdata;
            for (int i = 1; i < NUM_TAPS; i++) begin
                hist[i] <= hist[i-1];
            end
            last_in <= ss_tlast;
        end
    end

    // held until the mac takes it
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (take) begin
            pending <= 1'b0;
        end
    end

    // unused upper entries read as zero
    always_comb begin
        window = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            window[i] = hist[i];
        end
    end

endmodule

//--- source/fir_regs.sv
`timescale 1ns/1ps

module fir_regs #(
    parameter int NUM_TAPS = 11
) (
    input  logic               axis_clk,
    input  logic               axis_rst_n,
    input  logic               awvalid,
    input  fir_pkg::addr_t     awaddr,
    output logic               awready,
    input  logic               wvalid,
    input  fir_pkg::data_t     wdata,
    output logic               wready,
    input  logic               arvalid,
    input  fir_pkg::addr_t     araddr,
    output logic               arready,
    output logic               rvalid,
    input  logic               rready,
    output fir_pkg::data_t     rdata,
    output fir_pkg::tap_bank_t taps,
    output logic               start_pulse,
    output logic               running,
    input  logic               last_done
);

    // first address past the coefficient window
    localparam fir_pkg::addr_t TAP_END =
        fir_pkg::addr_t'(fir_pkg::ADDR_TAP_BASE + 4 * NUM_TAPS);

    fir_pkg::ap_ctrl_t ctrl;
    fir_pkg::data_t    data_length;
    logic              wr_ack;
    logic              wr_fire;
    logic              rd_fire;
    logic              ctrl_rd;
    logic              start_req;

    function automatic logic is_tap(input fir_pkg::addr_t addr);
        return (addr >= fir_pkg::ADDR_TAP_BASE) && (addr < TAP_END) &&
               (addr[1:0] == 2'b00);
    endfunction

    function automatic logic [fir_pkg::TAP_IDX_WIDTH-1:0] tap_index(
        input fir_pkg::addr_t addr
    );
        fir_pkg::addr_t offset;
        offset = addr - fir_pkg::ADDR_TAP_BASE;
        return offset[fir_pkg::TAP_IDX_WIDTH+1:2];
    endfunction

    ////////////////////////////////////////////////////////////
    // bus handshakes
    ////////////////////////////////////////////////////////////

    // address and data are accepted together, one cycle after both show up
    assign awready = wr_ack;
    assign wready  = wr_ack;
    assign wr_fire = wr_ack & awvalid & wvalid;
    assign rd_fire = arready & arvalid;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ack  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            wr_ack  <= awvalid & wvalid & ~wr_ack;
            // no new read address while a response is still out
            arready <= arvalid & ~arready & ~rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // read mux
    always_ff @(posedge axis_clk) begin
        if (rd_fire) begin
            if (araddr == fir_pkg::ADDR_AP_CTRL) begin
                rdata <= fir_pkg::data_t'(ctrl);
            end else if (araddr == fir_pkg::ADDR_DATA_LEN) begin
                rdata <= data_length;
            end else if (is_tap(araddr)) begin
                rdata <= ctrl.idle ? taps[tap_index(araddr)] : fir_pkg::TAP_BUSY_VALUE;
            end else begin
                rdata <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // control word
    ////////////////////////////////////////////////////////////

    assign ctrl_rd   = rd_fire && (araddr == fir_pkg::ADDR_AP_CTRL);
    assign start_req = wr_fire && (awaddr == fir_pkg::ADDR_AP_CTRL) && wdata[0] && ctrl.idle;
    assign running   = ~ctrl.idle & ~ctrl.done;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ctrl        <= '0;
            ctrl.idle   <= 1'b1;
            start_pulse <= 1'b0;
        end else begin
            start_pulse <= start_req;
            // start drops as the run begins
            if (start_req) begin
                ctrl.start <= 1'b1;
            end else if (start_pulse) begin
                ctrl.start <= 1'b0;
            end
            // done is clear-on-read, and that read also brings idle back
            if (last_done) begin
                ctrl.done <= 1'b1;
            end else if (ctrl_rd) begin
                ctrl.done <= 1'b0;
            end
            if (start_pulse) begin
                ctrl.idle <= 1'b0;
            end else if (ctrl_rd && ctrl.done) begin
                ctrl.idle <= 1'b1;
            end
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            data_length <= '0;
        end else if (wr_fire && (awaddr == fir_pkg::ADDR_DATA_LEN) && ctrl.idle) begin
            data_length <= wdata;
        end
    end

    // coefficient bank, written only while idle
    always_ff @(posedge axis_clk) begin
        if (wr_fire && ctrl.idle && is_tap(awaddr)) begin
            taps[tap_index(awaddr)] <= wdata;
        end
    end

endmodule

//--- source/fir_pkg.sv
package fir_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 12;

    // register map covers up to this many coefficients
    localparam int MAX_TAPS      = 32;
    localparam int TAP_IDX_WIDTH = $clog2(MAX_TAPS);

    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0]        addr_t;

    ////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////

    localparam addr_t ADDR_AP_CTRL  = 12'h000;
    localparam addr_t ADDR_DATA_LEN = 12'h010;
    // coefficient i at ADDR_TAP_BASE + 4*i
    localparam addr_t ADDR_TAP_BASE = 12'h040;

    // coefficient readback while a run is active
    localparam data_t TAP_BUSY_VALUE = '1;

    ////////////////////////////////////////////////////////////
    // shared types
    ////////////////////////////////////////////////////////////

    // control word, bit 0 start, bit 1 done, bit 2 idle
    typedef struct packed {
        logic [DATA_WIDTH-4:0] reserved;
        logic                  idle;
        logic                  done;
        logic                  start;
    } ap_ctrl_t;

    // one stream beat, used for input samples and for results
    typedef struct packed {
        data_t data;
        logic  last;
    } sample_t;

    // coefficient bank, also the shape of the history window
    typedef data_t [MAX_TAPS-1:0] tap_bank_t;

endpackage
